//--- src/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

//////////////////// Character format

// One start bit, 8 data bits, one stop bit
`define UART_DATA_BITS 8

// Bytes per link frame, index 0 goes out first
`define UART_FRAME_BYTES 4

//////////////////// Bit timing

`define UART_OVERSAMPLE 16     // Ticks per bit
`define UART_STOP_TICKS 16     // Ticks in the stop bit

// 100 MHz / (9600 * 16) rounds to 651
`define UART_BAUD_DIV 651

//////////////////// Link mode markers

// Frame A..A sets link mode
`define UART_MARK_SET 8'd65

// Frame C..C clears link mode
`define UART_MARK_CLEAR 8'd67

`endif

//--- src/uart_pkg.sv
`include "uart_params.svh"

package uart_pkg;

    // One data byte on the wire
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // Whole frame with element 0 sent or received first
    typedef uart_byte_t [`UART_FRAME_BYTES-1:0] uart_frame_t;

    //////////////////// Byte links

    // Receiver to frame assembler
    typedef struct packed {
        logic       valid;  // One-cycle pulse per byte
        uart_byte_t data;   // Held until the next byte lands
    } rx_byte_t;

    // Frame sender to transmitter
    typedef struct packed {
        logic       start;  // One-cycle pulse while the transmitter idles
        uart_byte_t data;   // Sampled with start
    } tx_byte_t;

    //////////////////// Receive report

    // Top-level receive output
    typedef struct packed {
        logic        frame_valid;  // Pulse per completed frame
        uart_frame_t frame;        // Last four bytes in arrival order
        logic        link_mode;    // Sticky marker flag
    } rx_report_t;

endpackage

//--- src/baud_tick_gen.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module baud_tick_gen #(
    parameter int CLKS_PER_TICK = `UART_BAUD_DIV  // Clocks per 16x tick
) (
    input  logic clk_100MHz,
    input  logic reset,
    output logic tick          // One-cycle pulse every CLKS_PER_TICK
);

    // At least one bit even for a divide by one
    localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_TICK - 1);

    logic [CNT_W-1:0] cnt;  // Free running, wraps on LAST_CNT

    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            cnt <= '0;
        end else if (cnt == LAST_CNT) begin
            cnt <= '0;  // Wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Tick on the last count of each period
    assign tick = (cnt == LAST_CNT);

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx import uart_pkg::*; (
    input  logic     clk_100MHz,
    input  logic     reset,
    input  logic     tick,     // 16x oversampling tick
    input  logic     rx,       // Serial line, idles high
    output rx_byte_t rx_byte
);

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);

    localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_OVERSAMPLE - 1);
    localparam logic [TICK_W-1:0] STOP_LAST = TICK_W'(`UART_STOP_TICKS - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(`UART_DATA_BITS - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t            state, state_next;
    logic [TICK_W-1:0] tick_cnt, tick_cnt_next;  // Ticks inside current bit
    logic [BIT_W-1:0]  bit_cnt, bit_cnt_next;    // Data bits taken so far
    uart_byte_t        shift_reg, shift_next;    // Assembles LSB first
    uart_byte_t        data_q;                   // Last complete byte
    logic              valid_next;
    logic              valid_q;
    logic [1:0]        rx_sync;                  // Two-flop synchronizer
    logic              rx_line;

    assign rx_line = rx_sync[1];

    //////////////////// Registers
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            rx_sync  <= '1;  // Line idles high
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            state    <= state_next;
            tick_cnt <= tick_cnt_next;
            bit_cnt  <= bit_cnt_next;
            valid_q  <= valid_next;
        end
    end

    // Payload only
    always_ff @(posedge clk_100MHz) begin
        shift_reg <= shift_next;
        if (valid_next) begin
            data_q <= shift_reg;  // Stable until the next stop bit
        end
    end

    //////////////////// Next state
    always_comb begin
        state_next    = state;
        tick_cnt_next = tick_cnt;
        bit_cnt_next  = bit_cnt;
        shift_next    = shift_reg;
        valid_next    = 1'b0;
        unique case (state)
            st_idle: begin
                if (!rx_line) begin  // Falling edge, start bit
                    state_next    = st_start;
                    tick_cnt_next = '0;
                end
            end
            st_start: begin
                if (tick) begin
                    if (tick_cnt == MID_TICK) begin
                        // Middle of start bit, high means a glitch
                        state_next    = rx_line ? st_idle : st_data;
                        tick_cnt_next = '0;
                        bit_cnt_next  = '0;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            st_data: begin
                if (tick) begin
                    if (tick_cnt == LAST_TICK) begin  // Mid data bit
                        tick_cnt_next = '0;
                        shift_next    = {rx_line, shift_reg[`UART_DATA_BITS-1:1]};
                        if (bit_cnt == LAST_BIT) begin
                            state_next = st_stop;
                        end else begin
                            bit_cnt_next = bit_cnt + 1'b1;
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            st_stop: begin
                if (tick) begin
                    if (tick_cnt == STOP_LAST) begin
                        state_next = st_idle;
                        valid_next = 1'b1;  // Byte complete
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
        endcase
    end

    assign rx_byte.valid = valid_q;
    assign rx_byte.data  = data_q;

endmodule

//--- src/rx_frame_assembler.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module rx_frame_assembler import uart_pkg::*; (
    input  logic       clk_100MHz,
    input  logic       reset,
    input  rx_byte_t   rx_byte,  // From receiver, valid pulses per byte
    output rx_report_t report
);

    localparam int CNT_W = $clog2(`UART_FRAME_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`UART_FRAME_BYTES - 1);

    uart_frame_t      frame_q;        // Shift register of received bytes
    uart_frame_t      frame_next;
    logic [CNT_W-1:0] byte_cnt;       // Position inside current frame
    logic             frame_valid_q;
    logic             link_mode_q;
    uart_byte_t       first_byte;     // Lands at index 0 on this shift
    uart_byte_t       last_byte;      // Incoming byte, last index

    // Older bytes move toward index 0, new byte enters at the top
    assign frame_next = {rx_byte.data, frame_q[`UART_FRAME_BYTES-1:1]};
    assign first_byte = frame_next[0];
    assign last_byte  = frame_next[`UART_FRAME_BYTES-1];

    always_ff @(posedge clk_100MHz) begin
        if (rx_byte.valid) begin
            frame_q <= frame_next;
        end
    end

    //////////////////// Frame boundary and markers
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            byte_cnt      <= '0;
            frame_valid_q <= 1'b0;
            link_mode_q   <= 1'b0;
        end else begin
            frame_valid_q <= 1'b0;  // Single-cycle pulse
            if (rx_byte.valid) begin
                if (byte_cnt == LAST_BYTE) begin
                    byte_cnt      <= '0;
                    frame_valid_q <= 1'b1;
                    // Marker rule, A..A sets and C..C clears
                    if (first_byte == `UART_MARK_SET && last_byte == `UART_MARK_SET) begin
                        link_mode_q <= 1'b1;
                    end else if (first_byte == `UART_MARK_CLEAR &&
                                 last_byte == `UART_MARK_CLEAR) begin
                        link_mode_q <= 1'b0;
                    end
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // No back-pressure, the next frame overwrites
    assign report.frame_valid = frame_valid_q;
    assign report.frame       = frame_q;
    assign report.link_mode   = link_mode_q;

endmodule

//--- src/tx_frame_sender.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module tx_frame_sender import uart_pkg::*; (
    input  logic        clk_100MHz,
    input  logic        reset,
    input  logic        tx_req,    // Client request, four-phase
    input  uart_frame_t tx_frame,  // Stable while tx_req is high
    output logic        tx_ack,
    output tx_byte_t    tx_byte,   // To transmitter
    input  logic        tx_done    // End of stop bit
);

    localparam int IDX_W = $clog2(`UART_FRAME_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`UART_FRAME_BYTES - 1);

    typedef enum logic [1:0] {st_idle, st_issue, st_wait_done, st_ack} state_t;

    state_t           state;
    logic [IDX_W-1:0] byte_idx;  // Byte being sent, 0 first
    uart_frame_t      frame_q;   // Latched client frame

    // Frame captured on the first edge with tx_req high
    always_ff @(posedge clk_100MHz) begin
        if (state == st_idle && tx_req) begin
            frame_q <= tx_frame;
        end
    end

    //////////////////// Handshake FSM
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            state    <= st_idle;
            byte_idx <= '0;
        end else begin
            unique case (state)
                st_idle: begin
                    if (tx_req) begin
                        state    <= st_issue;
                        byte_idx <= '0;
                    end
                end
                st_issue: state <= st_wait_done;  // Start pulse lasts one cycle
                st_wait_done: begin
                    if (tx_done) begin
                        if (byte_idx == LAST_IDX) begin
                            state <= st_ack;  // Last stop bit done
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= st_issue;
                        end
                    end
                end
                st_ack: begin
                    if (!tx_req) begin  // Ack drops one cycle after req
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Transmitter is back in idle whenever we reach issue
    assign tx_byte.start = (state == st_issue);
    assign tx_byte.data  = frame_q[byte_idx];
    assign tx_ack        = (state == st_ack);  // Held while client keeps req

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx import uart_pkg::*; (
    input  logic     clk_100MHz,
    input  logic     reset,
    input  logic     tick,      // 16x oversampling tick
    input  tx_byte_t tx_byte,   // start pulse plus byte
    output logic     tx_done,   // Pulse on the last stop tick
    output logic     tx         // Serial line, idles high
);

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);

    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_OVERSAMPLE - 1);
    localparam logic [TICK_W-1:0] STOP_LAST = TICK_W'(`UART_STOP_TICKS - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(`UART_DATA_BITS - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t            state, state_next;
    logic [TICK_W-1:0] tick_cnt, tick_cnt_next;
    logic [BIT_W-1:0]  bit_cnt, bit_cnt_next;   // Data bits sent
    uart_byte_t        data_reg, data_next;     // Shifts right, LSB on the line
    logic              tx_reg, tx_next;         // Registered line, no glitches

    //////////////////// Registers
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx_reg   <= 1'b1;  // Line high out of reset
        end else begin
            state    <= state_next;
            tick_cnt <= tick_cnt_next;
            bit_cnt  <= bit_cnt_next;
            tx_reg   <= tx_next;
        end
    end

    always_ff @(posedge clk_100MHz) begin
        data_reg <= data_next;
    end

    // tx_next always carries the level of the bit about to be on the line
    // Start bit runs to the 16th free-running tick, so the first one can be short
    always_comb begin
        state_next    = state;
        tick_cnt_next = tick_cnt;
        bit_cnt_next  = bit_cnt;
        data_next     = data_reg;
        tx_next       = tx_reg;
        tx_done       = 1'b0;
        unique case (state)
            st_idle: begin
                tx_next = 1'b1;
                if (tx_byte.start) begin
                    state_next    = st_start;
                    tick_cnt_next = '0;
                    data_next     = tx_byte.data;
                    tx_next       = 1'b0;  // Low on the next cycle
                end
            end
            st_start: begin
                if (tick) begin
                    if (tick_cnt == LAST_TICK) begin
                        state_next    = st_data;
                        tick_cnt_next = '0;
                        bit_cnt_next  = '0;
                        tx_next       = data_reg[0];  // First data bit
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            st_data: begin
                if (tick) begin
                    if (tick_cnt == LAST_TICK) begin
                        tick_cnt_next = '0;
                        data_next     = data_reg >> 1;
                        if (bit_cnt == LAST_BIT) begin
                            state_next = st_stop;
                            tx_next    = 1'b1;  // Stop bit
                        end else begin
                            bit_cnt_next = bit_cnt + 1'b1;
                            tx_next      = data_reg[1];
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            st_stop: begin
                if (tick) begin
                    if (tick_cnt == STOP_LAST) begin
                        state_next = st_idle;
                        tx_done    = 1'b1;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
        endcase
    end

    assign tx = tx_reg;

endmodule

//--- src/uart_link_top.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_link_top import uart_pkg::*; #(
    parameter int CLKS_PER_TICK = `UART_BAUD_DIV  // 9600 baud at 100 MHz
) (
    input  logic        clk_100MHz,
    input  logic        reset,
    input  logic        rx,        // Serial in
    output logic        tx,        // Serial out
    input  logic        tx_req,    // Client handshake
    input  uart_frame_t tx_frame,
    output logic        tx_ack,
    output rx_report_t  report     // Receive side frames and link mode
);

    logic     tick;     // Shared 16x tick
    rx_byte_t rx_byte;  // Receiver to assembler
    tx_byte_t tx_byte;  // Sender to transmitter
    logic     tx_done;

    baud_tick_gen #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) baud_tick_gen_i (
        .clk_100MHz(clk_100MHz),
        .reset(reset),
        .tick(tick)
    );

    //////////////////// Receive path
    uart_rx uart_rx_i (
        .clk_100MHz(clk_100MHz),
        .reset(reset),
        .tick(tick),
        .rx(rx),
        .rx_byte(rx_byte)
    );

    rx_frame_assembler rx_frame_assembler_i (
        .clk_100MHz(clk_100MHz),
        .reset(reset),
        .rx_byte(rx_byte),
        .report(report)
    );

    //////////////////// Transmit path
    tx_frame_sender tx_frame_sender_i (
        .clk_100MHz(clk_100MHz),
        .reset(reset),
        .tx_req(tx_req),
        .tx_frame(tx_frame),
        .tx_ack(tx_ack),
        .tx_byte(tx_byte),
        .tx_done(tx_done)
    );

    uart_tx uart_tx_i (
        .clk_100MHz(clk_100MHz),
        .reset(reset),
        .tick(tick),
        .tx_byte(tx_byte),
        .tx_done(tx_done),
        .tx(tx)
    );

endmodule

//--- dv/uart_link_checker.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_link_checker #(
    parameter int CLKS_PER_TICK = `UART_BAUD_DIV  // Same divisor as the DUT
) (
    input logic clk_100MHz,
    input logic reset,
    input logic tick,      // 16x tick inside the DUT
    input logic tx_start,  // Sender to transmitter start pulse
    input logic tx_done,   // End of stop bit
    input logic tx,        // Serial line out
    input logic tx_req,
    input logic tx_ack
);

    // First tick of the start bit lands 1 to CLKS_PER_TICK cycles in
    localparam int START_MIN = (`UART_OVERSAMPLE - 1) * CLKS_PER_TICK + 1;

    int fail_cnt = 0;  // Failed assertions so far

    //////////////////// Handshake
    ack_needs_req: assert property (@(posedge clk_100MHz) disable iff (reset)
        $rose(tx_ack) |-> tx_req)
        else begin $error("tx_ack rose with tx_req low"); fail_cnt++; end

    ack_holds: assert property (@(posedge clk_100MHz) disable iff (reset)
        tx_ack && tx_req |=> tx_ack)
        else begin $error("tx_ack dropped while tx_req high"); fail_cnt++; end

    ack_release: assert property (@(posedge clk_100MHz) disable iff (reset)
        tx_ack && !tx_req |=> !tx_ack)
        else begin $error("tx_ack not released one cycle after tx_req"); fail_cnt++; end

    // Stalled client, no new byte and a quiet line
    no_restart: assert property (@(posedge clk_100MHz) disable iff (reset)
        tx_ack |-> !tx_start && tx)
        else begin $error("Start bit issued while tx_ack high"); fail_cnt++; end

    //////////////////// Serial line
    start_ticks: assert property (@(posedge clk_100MHz) disable iff (reset)
        tx_start |=> (!tx throughout (tick [-> `UART_OVERSAMPLE])))
        else begin $error("Start bit shorter than 16 ticks"); fail_cnt++; end

    start_cycles: assert property (@(posedge clk_100MHz) disable iff (reset)
        tx_start |=> !tx [*START_MIN])
        else begin $error("Start bit too short in cycles"); fail_cnt++; end

    stop_high: assert property (@(posedge clk_100MHz) disable iff (reset)
        tx_done |-> tx)
        else begin $error("Line low at end of stop bit"); fail_cnt++; end

    idle_line: assert property (@(posedge clk_100MHz) disable iff (reset)
        !tx_req && !tx_ack |-> tx)
        else begin $error("Line low between frames"); fail_cnt++; end

    reset_line: assert property (@(posedge clk_100MHz)
        $fell(reset) |-> tx && !tx_ack)
        else begin $error("Line or ack wrong after reset"); fail_cnt++; end

endmodule

//--- dv/uart_link_tb.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_link_tb import uart_pkg::*; ();

    localparam int TB_CLKS_PER_TICK = 4;  // 64 cycles per bit
    localparam int CYCLES_PER_BYTE  = 10 * `UART_OVERSAMPLE * TB_CLKS_PER_TICK;
    localparam int MAX_FRAMES       = 15;  // 8 loopback + 7 marker
    // Longest run plus 30 percent
    localparam int CYCLE_LIMIT = MAX_FRAMES * `UART_FRAME_BYTES * CYCLES_PER_BYTE * 13 / 10;

    logic        clk_100MHz;
    logic        reset;
    logic        tx_req;
    uart_frame_t tx_frame;
    logic        tx_ack;
    logic        serial_line;  // tx looped back to rx
    rx_report_t  report;

    int unsigned cycle_cnt    = 0;
    int          data_errors  = 0;
    int          valid_cnt    = 0;  // frame_valid pulses seen
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic [31:0] rng_state    = 32'hc9fd_aa08;
    logic        expected_mode = 1'b0;  // Link mode by the marker rule
    rx_report_t  rx_q[$];               // Reports in arrival order

    uart_link_top #(
        .CLKS_PER_TICK(TB_CLKS_PER_TICK)
    ) uart_link_top_i (
        .clk_100MHz(clk_100MHz),
        .reset(reset),
        .rx(serial_line),
        .tx(serial_line),
        .tx_req(tx_req),
        .tx_frame(tx_frame),
        .tx_ack(tx_ack),
        .report(report)
    );

    bind uart_link_top uart_link_checker #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) uart_link_checker_i (
        .clk_100MHz(clk_100MHz),
        .reset(reset),
        .tick(tick),
        .tx_start(tx_byte.start),
        .tx_done(tx_done),
        .tx(tx),
        .tx_req(tx_req),
        .tx_ack(tx_ack)
    );

    //////////////////// Clock, cycle count, watchdog
    initial begin
        clk_100MHz = 1'b0;
        forever #5 clk_100MHz = ~clk_100MHz;
    end

    always @(posedge clk_100MHz) cycle_cnt <= cycle_cnt + 1;

    initial begin : watchdog
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("Timeout after %0d cycles, DUT stopped responding", CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    // Receive monitor
    always @(posedge clk_100MHz) begin
        if (!reset && report.frame_valid) begin
            rx_q.push_back(report);
            valid_cnt++;
        end
    end

    //////////////////// Helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int checker_failures();
        return uart_link_top_i.uart_link_checker_i.fail_cnt;
    endfunction

    // A..A sets, C..C clears, anything else holds
    function automatic logic expect_link_mode(input logic current, input uart_frame_t f);
        if (f[0] == `UART_MARK_SET && f[`UART_FRAME_BYTES-1] == `UART_MARK_SET) begin
            return 1'b1;
        end
        if (f[0] == `UART_MARK_CLEAR && f[`UART_FRAME_BYTES-1] == `UART_MARK_CLEAR) begin
            return 1'b0;
        end
        return current;
    endfunction

    task automatic random_frame(output uart_frame_t f);
        rng_state = xorshift32(rng_state);
        f         = rng_state;  // One word fills the frame
    endtask

    // Random middle bytes between chosen end bytes
    task automatic marker_frame(input uart_byte_t first, input uart_byte_t last,
                                output uart_frame_t f);
        random_frame(f);
        f[0]                   = first;
        f[`UART_FRAME_BYTES-1] = last;
    endtask

    task automatic check_equal(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual)
        else begin
            $display("** Error: %s %s expected %h actual %h", test, what, expected, actual);
            data_errors++;
        end
    endtask

    // Four-phase client where hold keeps req high after ack
    task automatic send_frame(input uart_frame_t frame, input int hold);
        @(posedge clk_100MHz);
        tx_req   <= 1'b1;
        tx_frame <= frame;
        while (!tx_ack) @(posedge clk_100MHz);
        repeat (hold) @(posedge clk_100MHz);
        tx_req <= 1'b0;
        while (tx_ack) @(posedge clk_100MHz);
    endtask

    task automatic send_and_check(input string test, input uart_frame_t frame, input int hold);
        rx_report_t got;
        send_frame(frame, hold);
        while (rx_q.size() == 0) @(posedge clk_100MHz);
        got           = rx_q.pop_front();
        expected_mode = expect_link_mode(expected_mode, frame);
        check_equal(test, "frame", frame, got.frame);
        check_equal(test, "link_mode", expected_mode, got.link_mode);
    endtask

    task automatic finish_test(input string test, input int data_before, input int chk_before);
        int new_errs;
        new_errs = (data_errors - data_before) + (checker_failures() - chk_before);
        tests_run++;
        if (new_errs == 0) begin
            $display("PASS  %s", test);
        end else begin
            tests_failed++;
            $display("FAIL  %s  %0d errors", test, new_errs);
        end
    endtask

    //////////////////// Tests
    initial begin : main
        uart_frame_t sent;
        int          d0;
        int          c0;
        int          v0;
        reset    = 1'b1;
        tx_req   = 1'b0;
        tx_frame = '0;
        repeat (4) @(posedge clk_100MHz);
        reset <= 1'b0;
        @(posedge clk_100MHz);

        d0 = data_errors;
        c0 = checker_failures();
        check_equal("reset_state", "tx", 1, serial_line);
        check_equal("reset_state", "tx_ack", 0, tx_ack);
        check_equal("reset_state", "frame_valid", 0, report.frame_valid);
        check_equal("reset_state", "link_mode", 0, report.link_mode);
        finish_test("reset_state", d0, c0);

        d0 = data_errors;
        c0 = checker_failures();
        v0 = valid_cnt;
        for (int i = 0; i < 8; i++) begin
            random_frame(sent);
            send_and_check("loopback_integrity", sent, 0);
        end
        check_equal("loopback_integrity", "frame_valid count", 8, valid_cnt - v0);
        finish_test("loopback_integrity", d0, c0);

        d0 = data_errors;
        c0 = checker_failures();
        // One marker end only, flag low
        marker_frame(`UART_MARK_SET, `UART_MARK_CLEAR, sent);
        send_and_check("marker_rule", sent, 0);
        marker_frame(`UART_MARK_CLEAR, `UART_MARK_SET, sent);
        send_and_check("marker_rule", sent, 0);
        marker_frame(`UART_MARK_SET, `UART_MARK_SET, sent);
        send_and_check("marker_rule", sent, 0);
        // One marker end only, flag high
        marker_frame(`UART_MARK_SET, `UART_MARK_CLEAR, sent);
        send_and_check("marker_rule", sent, 20);  // Client stalls with req high
        marker_frame(`UART_MARK_CLEAR, `UART_MARK_SET, sent);
        send_and_check("marker_rule", sent, 0);
        random_frame(sent);
        send_and_check("marker_rule", sent, 0);
        marker_frame(`UART_MARK_CLEAR, `UART_MARK_CLEAR, sent);
        send_and_check("marker_rule", sent, 0);
        finish_test("marker_rule", d0, c0);

        $display("Tests %0d run, %0d failed, %0d data errors, %0d assertion failures",
                 tests_run, tests_failed, data_errors, checker_failures());
        if (tests_failed == 0 && data_errors == 0 && checker_failures() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+src
src/uart_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/rx_frame_assembler.sv
src/tx_frame_sender.sv
src/uart_tx.sv
src/uart_link_top.sv
dv/uart_link_checker.sv
dv/uart_link_tb.sv

//--- Bender.yml
package:
  name: uart_link

sources:
  - include_dirs:
      - src
    files:
      - src/uart_pkg.sv
      - src/baud_tick_gen.sv
      - src/uart_rx.sv
      - src/rx_frame_assembler.sv
      - src/tx_frame_sender.sv
      - src/uart_tx.sv
      - src/uart_link_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - dv/uart_link_checker.sv
      - dv/uart_link_tb.sv
